// ==== src.f ====
+incdir+common
common/kwm_pkg.sv
rule_slot/rule_dfa.sv
rule_slot/rule_slot.sv
verilog/pkt_scanner.sv
verilog/match_tally.sv
verilog/kwm_top.sv
dv/clk_rst_gen.sv
dv/kwm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the keyword matcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=kwm_sim

verilator --binary --timing --assert -j 0 -f src.f --top-module kwm_tb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "No pass message found in $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== dv/kwm_tb.sv ====
`include "kwm_consts.svh"

module kwm_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import kwm_pkg::*;

  localparam int NR           = `KWM_NUM_RULES;
  localparam int LEN          = `KWM_KEY_LEN;
  localparam int SB           = `KWM_STREAM_BITS;
  localparam int RB           = $clog2(`KWM_NUM_RULES);
  // Last beat to result.vld, in cycles
  localparam int LATENCY      = 6;
  localparam int NUM_RANDOM   = 40;
  localparam int MAX_RAND_LEN = 12;

  logic          clk;
  logic          rst_n;
  pkt_beat_t     in_beat;
  logic [RB-1:0] rd_rule;
  result_t       result;
  logic [15:0]   rd_count;

  // Packet list, directed table first, random packets after
  int unsigned   pkt_stream[$];
  bit            pkt_new[$];
  logic [NR-1:0] pkt_en[$];
  string         pkt_pay[$];
  logic [NR-1:0] pkt_exp[$];
  bit            pkt_has_exp[$];

  // Reference model
  string         keys [NR];
  int            model_state [NR][1 << SB];
  int unsigned   model_count [NR];
  // Streams whose state a rule has saved at least once
  bit            state_known [NR][1 << SB];
  int            seed = 40;
  int            wd_cycles = 0;

  clk_rst_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (4)
  ) i_clk_rst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  kwm_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (in_beat),
    .rd_rule  (rd_rule),
    .result   (result),
    .rd_count (rd_count)
  );

  task automatic stop_on_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
    $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
    $display("Result: FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic stop_with_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "test error");
  endtask

  task automatic add_packet(input int unsigned stream, input bit is_new,
                            input logic [NR-1:0] en, input string pay,
                            input bit has_exp, input logic [NR-1:0] exp);
    pkt_stream.push_back(stream);
    pkt_new.push_back(is_new);
    pkt_en.push_back(en);
    pkt_pay.push_back(pay);
    pkt_has_exp.push_back(has_exp);
    pkt_exp.push_back(exp);
  endtask

  // Restart-on-mismatch search step, returns LEN on a full keyword
  function automatic int advance(input string key, input int st, input byte ch);
    if (st < LEN && ch == key[st])
      return st + 1;
    else if (ch == key[0])
      return 1;
    else
      return 0;
  endfunction

  // Runs one packet through every rule, updates saved state and counts
  function automatic logic [NR-1:0] model_packet(input int unsigned stream, input bit is_new,
                                                 input logic [NR-1:0] en, input string pay);
    logic [NR-1:0] mask;
    int            st;
    bit            hit;
    mask = '0;
    for (int r = 0; r < NR; r++)
    begin
      st  = is_new ? 0 : model_state[r][stream];
      hit = 1'b0;
      for (int i = 0; i < pay.len(); i++)
      begin
        st = advance(keys[r], st, pay[i]);
        if (st == LEN)
        begin
          hit = 1'b1;
          st  = 0;
        end
      end
      // Disabled rule keeps old state and count
      if (en[r])
      begin
        model_state[r][stream] = st;
        if (hit)
          model_count[r]++;
        mask[r] = hit;
      end
    end
    return mask;
  endfunction

  task automatic build_table();
    // Every keyword once on a fresh stream
    add_packet(1, 1'b1, 4'b1111, "xUSERyPASSzrootqexec!", 1'b1, 4'b1111);
    // Keyword split across two packets of one stream
    add_packet(2, 1'b1, 4'b1111, "abcUS", 1'b1, 4'b0000);
    add_packet(2, 1'b0, 4'b1111, "ERxyz", 1'b1, 4'b0001);
    // Same split, second packet restarts the stream
    add_packet(4, 1'b1, 4'b1111, "helloUS", 1'b1, 4'b0000);
    add_packet(4, 1'b1, 4'b1111, "ERhello", 1'b1, 4'b0000);
    // Rule 0 masked off while its keyword is present
    add_packet(3, 1'b1, 4'b1111, "nothing", 1'b1, 4'b0000);
    add_packet(3, 1'b0, 4'b1110, "USERroot", 1'b1, 4'b0100);
    add_packet(3, 1'b0, 4'b1111, "USER", 1'b1, 4'b0001);
    // Two streams interleaved, each with its own partial match
    add_packet(5, 1'b1, 4'b1111, "aaPA", 1'b1, 4'b0000);
    add_packet(6, 1'b1, 4'b1111, "bbro", 1'b1, 4'b0000);
    add_packet(5, 1'b0, 4'b1111, "SSaa", 1'b1, 4'b0010);
    add_packet(6, 1'b0, 4'b1111, "otbb", 1'b1, 4'b0100);
    add_packet(5, 1'b0, 4'b1111, "zzex", 1'b1, 4'b0000);
    add_packet(6, 1'b0, 4'b1111, "ecUS", 1'b1, 4'b0000);
    add_packet(5, 1'b0, 4'b1111, "ecER", 1'b1, 4'b1000);
    add_packet(6, 1'b0, 4'b1111, "ERqq", 1'b1, 4'b0001);
  endtask

  task automatic build_random();
    string         alpha;
    string         pay;
    int unsigned   stream;
    int unsigned   len;
    logic [NR-1:0] en;
    bit            is_new;
    // Keyword letters so hits and splits happen often
    alpha = "USERPASrotexcz";
    for (int p = 0; p < NUM_RANDOM; p++)
    begin
      stream = 8 + ($unsigned($random(seed)) % 4);
      len    = 1 + ($unsigned($random(seed)) % MAX_RAND_LEN);
      en     = NR'($random(seed));
      is_new = ($unsigned($random(seed)) % 4) == 0;
      // Never restore a state that was not saved yet
      for (int r = 0; r < NR; r++)
      begin
        if (!state_known[r][stream])
          is_new = 1'b1;
      end
      for (int r = 0; r < NR; r++)
      begin
        if (en[r])
          state_known[r][stream] = 1'b1;
      end
      pay = "";
      for (int i = 0; i < len; i++)
        pay = $sformatf("%s%c", pay, alpha[$unsigned($random(seed)) % alpha.len()]);
      add_packet(stream, is_new, en, pay, 1'b0, '0);
    end
  endtask

  // Header beat, then one beat per character, back to back
  task automatic send_packet(input int unsigned stream, input bit is_new,
                             input logic [NR-1:0] en, input string pay);
    @(posedge clk);
    #1;
    in_beat                     = '0;
    in_beat.vld                 = 1'b1;
    in_beat.first               = 1'b1;
    in_beat.word.hdr.stream_id  = stream[SB-1:0];
    in_beat.word.hdr.new_stream = is_new;
    in_beat.word.hdr.rule_en    = en;
    for (int i = 0; i < pay.len(); i++)
    begin
      @(posedge clk);
      #1;
      in_beat               = '0;
      in_beat.vld           = 1'b1;
      in_beat.last          = (i == pay.len() - 1);
      in_beat.word.pay.char = pay[i];
    end
  endtask

  // Result must show up exactly LATENCY cycles after the last beat
  task automatic await_result(input int unsigned stream, input logic [NR-1:0] exp_mask);
    for (int c = 1; c <= LATENCY; c++)
    begin
      @(posedge clk);
      #1;
      in_beat = '0;
      #1;
      if (c < LATENCY)
        assert (result.vld == 1'b0)
        else stop_on_mismatch("result.vld", 32'(result.vld), 32'd0);
    end
    assert (result.vld == 1'b1)
    else stop_on_mismatch("result.vld", 32'(result.vld), 32'd1);
    assert (result.stream_id == stream[SB-1:0])
    else stop_on_mismatch("result.stream_id", 32'(result.stream_id), stream);
    assert (result.hit_mask == exp_mask)
    else stop_on_mismatch("result.hit_mask", 32'(result.hit_mask), 32'(exp_mask));
  endtask

  // Walk the count readout over all rules
  task automatic check_counts();
    for (int r = 0; r < NR; r++)
    begin
      @(posedge clk);
      #1;
      rd_rule = RB'(r);
      #1;
      assert (rd_count == model_count[r][15:0])
      else stop_on_mismatch($sformatf("rd_count[%0d]", r), 32'(rd_count), model_count[r]);
    end
  endtask

  // Watchdog, armed once the packet list is known
  initial
  begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("ERROR at %0t ns: watchdog expired before all packets were checked", $time);
    $display("Result: FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial
  begin
    int            longest;
    logic [NR-1:0] mask;
    in_beat = '0;
    rd_rule = '0;
    keys[0] = `KWM_KEY0;
    keys[1] = `KWM_KEY1;
    keys[2] = `KWM_KEY2;
    keys[3] = `KWM_KEY3;
    for (int r = 0; r < NR; r++)
    begin
      model_count[r] = 0;
      for (int s = 0; s < (1 << SB); s++)
      begin
        model_state[r][s] = 0;
        state_known[r][s] = 1'b0;
      end
    end
    build_table();
    build_random();
    longest = 0;
    foreach (pkt_pay[p])
    begin
      if (pkt_pay[p].len() > longest)
        longest = pkt_pay[p].len();
    end
    // Header, payload, latency, readout and gap for each packet, then doubled
    wd_cycles = 2 * (8 + pkt_pay.size() * (1 + longest + LATENCY + NR + `KWM_MIN_GAP));
    wait (rst_n === 1'b1);
    for (int p = 0; p < pkt_pay.size(); p++)
    begin
      mask = model_packet(pkt_stream[p], pkt_new[p], pkt_en[p], pkt_pay[p]);
      if (pkt_has_exp[p])
        assert (mask == pkt_exp[p])
        else stop_with_error($sformatf("table entry %0d expects hit mask %b but model gives %b",
                                       p, pkt_exp[p], mask));
      send_packet(pkt_stream[p], pkt_new[p], pkt_en[p], pkt_pay[p]);
      await_result(pkt_stream[p], mask);
      check_counts();
      repeat (`KWM_MIN_GAP) @(posedge clk);
    end
    // Final count readout after every packet
    check_counts();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== dv/clk_rst_gen.sv ====
module clk_rst_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset held low for a few edges, released just after an edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== verilog/kwm_top.sv ====
`include "kwm_consts.svh"

module kwm_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  kwm_pkg::pkt_beat_t                in_beat,
  input  logic [$clog2(`KWM_NUM_RULES)-1:0] rd_rule,
  output kwm_pkg::result_t                  result,
  output logic [15:0]                       rd_count
);

  import kwm_pkg::*;

  localparam int KW = 8 * `KWM_KEY_LEN;
  // Rule 0 keyword in the low slice
  localparam logic [`KWM_NUM_RULES*KW-1:0] KEYS = {`KWM_KEY3, `KWM_KEY2, `KWM_KEY1, `KWM_KEY0};

  slot_ctl_t ctl;
  slot_out_t slot_out [`KWM_NUM_RULES];

  pkt_scanner i_scanner (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_beat (in_beat),
    .ctl     (ctl)
  );

  // One slot per keyword, each with its own enable bit
  for (genvar g = 0; g < `KWM_NUM_RULES; g++)
  begin : g_slot
    rule_slot #(
      .KEYWORD (KEYS[g*KW +: KW])
    ) i_slot (
      .clk    (clk),
      .rst_n  (rst_n),
      .ctl    (ctl),
      .enable (ctl.rule_en[g]),
      .out    (slot_out[g])
    );
  end

  match_tally i_tally (
    .clk       (clk),
    .rst_n     (rst_n),
    .slots     (slot_out),
    .eop       (ctl.eop),
    .rule_en   (ctl.rule_en),
    .stream_id (ctl.stream_id),
    .rd_rule   (rd_rule),
    .result    (result),
    .rd_count  (rd_count)
  );

endmodule

// ==== verilog/match_tally.sv ====
`include "kwm_consts.svh"

module match_tally (
  input  logic                               clk,
  input  logic                               rst_n,
  input  kwm_pkg::slot_out_t                 slots [`KWM_NUM_RULES],
  input  logic                               eop,
  input  logic [`KWM_NUM_RULES-1:0]          rule_en,
  input  logic [`KWM_STREAM_BITS-1:0]        stream_id,
  input  logic [$clog2(`KWM_NUM_RULES)-1:0]  rd_rule,
  output kwm_pkg::result_t                   result,
  output logic [15:0]                        rd_count
);

  logic [`KWM_NUM_RULES-1:0]   fired_vec;
  logic                        res_vld;
  logic [`KWM_STREAM_BITS-1:0] res_stream;
  logic [`KWM_NUM_RULES-1:0]   res_mask;

  // Gather fired bits into one mask
  always_comb
  begin
    for (int i = 0; i < `KWM_NUM_RULES; i++)
      fired_vec[i] = slots[i].fired;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      res_vld <= 1'b0;
    else
      res_vld <= eop;
  end

  // Snapshot of the packet's hits at eop
  always_ff @(posedge clk)
  begin
    if (eop)
    begin
      res_stream <= stream_id;
      // Disabled rules never report
      res_mask   <= fired_vec & rule_en;
    end
  end

  assign result = '{vld: res_vld, stream_id: res_stream, hit_mask: res_mask};

  // Count readout, no register
  assign rd_count = slots[rd_rule].count;

  // One result per packet, and packets are spaced apart
  a_single_result: assert property (@(posedge clk) disable iff (!rst_n)
    result.vld |=> !result.vld);

endmodule

// ==== verilog/pkt_scanner.sv ====
`include "kwm_consts.svh"

module pkt_scanner (
  input  logic               clk,
  input  logic               rst_n,
  input  kwm_pkg::pkt_beat_t in_beat,
  output kwm_pkg::slot_ctl_t ctl
);

  localparam int CNT_W = $clog2(`KWM_EOP_DELAY + 1);

  logic                        hdr_beat;
  logic                        pay_beat;
  logic                        busy;
  logic                        in_pkt;
  logic                        load_q;
  // Latched per packet from the header
  logic                        new_q;
  logic [`KWM_STREAM_BITS-1:0] stream_q;
  logic [`KWM_NUM_RULES-1:0]   rule_en_q;
  // Two-stage character pipe
  logic                        pay_vld_s1;
  logic                        pay_last_s1;
  logic [7:0]                  pay_char_s1;
  logic                        char_vld_q;
  logic                        pay_last_s2;
  logic [7:0]                  char_q;
  // End-of-packet countdown
  logic [CNT_W-1:0]            eop_cnt;
  logic                        eop_q;

  assign hdr_beat = in_beat.vld && in_beat.first;
  assign pay_beat = in_beat.vld && !in_beat.first;

  // Packet open, or its tail still draining towards eop
  assign busy = in_pkt || pay_last_s1 || pay_last_s2 || (eop_cnt != '0) || eop_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      in_pkt      <= 1'b0;
      load_q      <= 1'b0;
      pay_vld_s1  <= 1'b0;
      pay_last_s1 <= 1'b0;
      char_vld_q  <= 1'b0;
      pay_last_s2 <= 1'b0;
      eop_cnt     <= '0;
      eop_q       <= 1'b0;
    end
    else
    begin
      // Load pulse one cycle after the header
      load_q <= hdr_beat;
      if (hdr_beat)
        in_pkt <= 1'b1;
      else if (pay_beat && in_beat.last)
        in_pkt <= 1'b0;
      // Characters trail the load pulse by one extra stage
      pay_vld_s1  <= pay_beat;
      pay_last_s1 <= pay_beat && in_beat.last;
      char_vld_q  <= pay_vld_s1;
      pay_last_s2 <= pay_last_s1;
      // Start countdown on the last character strobe
      if (pay_last_s2)
        eop_cnt <= CNT_W'(`KWM_EOP_DELAY - 1);
      else if (eop_cnt != '0)
        eop_cnt <= eop_cnt - 1'b1;
      eop_q <= (eop_cnt == CNT_W'(1));
    end
  end

  always_ff @(posedge clk)
  begin
    if (hdr_beat)
    begin
      stream_q  <= in_beat.word.hdr.stream_id;
      new_q     <= in_beat.word.hdr.new_stream;
      rule_en_q <= in_beat.word.hdr.rule_en;
    end
    pay_char_s1 <= in_beat.word.pay.char;
    char_q      <= pay_char_s1;
  end

  assign ctl = '{load_state: load_q, new_stream: new_q, stream_id: stream_q,
                 char_vld: char_vld_q, char: char_q, eop: eop_q, rule_en: rule_en_q};

  // Sender keeps the idle gap until the previous eop has gone out
  a_hdr_gap: assert property (@(posedge clk) disable iff (!rst_n) hdr_beat |-> !busy);

  // Payload only inside a packet opened by a header
  a_pay_in_pkt: assert property (@(posedge clk) disable iff (!rst_n) pay_beat |-> in_pkt);

endmodule

// ==== rule_slot/rule_slot.sv ====
`include "kwm_consts.svh"

module rule_slot #(
  parameter logic [8*`KWM_KEY_LEN-1:0] KEYWORD = `KWM_KEY0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  kwm_pkg::slot_ctl_t ctl,
  input  logic               enable,
  output kwm_pkg::slot_out_t out
);

  localparam int NUM_STREAMS = 1 << `KWM_STREAM_BITS;

  // Saved automaton state per stream
  logic [`KWM_STATE_BITS-1:0] state_mem [NUM_STREAMS];

  // Restored state, one cycle after load_state
  logic                       state_ld_vld;
  logic [`KWM_STATE_BITS-1:0] state_ld;
  // Registered automaton inputs
  logic                       char_vld_r;
  logic [7:0]                 char_r;
  logic                       state_vld_r;
  logic [`KWM_STATE_BITS-1:0] state_r;
  // Automaton outputs, raw and registered
  logic [`KWM_STATE_BITS-1:0] dfa_state;
  logic                       dfa_accept;
  logic [`KWM_STATE_BITS-1:0] state_out_r;
  logic                       accept_r;
  // Per-packet match and matched packet count
  logic                       match_flag;
  logic                       hit;
  logic [15:0]                count;

  // Last character's accept lands on the eop cycle, so fold it in
  assign hit = match_flag || accept_r;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_ld_vld <= 1'b0;
      char_vld_r   <= 1'b0;
      state_vld_r  <= 1'b0;
      accept_r     <= 1'b0;
      match_flag   <= 1'b0;
      count        <= '0;
    end
    else
    begin
      state_ld_vld <= ctl.load_state;
      char_vld_r   <= ctl.char_vld;
      state_vld_r  <= state_ld_vld;
      accept_r     <= dfa_accept;
      // New packet starts without a match
      if (ctl.load_state)
        match_flag <= 1'b0;
      if (accept_r)
        match_flag <= 1'b1;
      if (ctl.eop)
      begin
        if (enable)
          count <= count + 16'(hit);
        else
          match_flag <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    // Fresh stream starts at state zero
    if (ctl.load_state)
      state_ld <= ctl.new_stream ? '0 : state_mem[ctl.stream_id];
    char_r      <= ctl.char;
    state_r     <= state_ld;
    state_out_r <= dfa_state;
    // Keep partial match for the next packet of this stream
    if (ctl.eop && enable)
      state_mem[ctl.stream_id] <= state_out_r;
  end

  rule_dfa #(
    .KEYWORD (KEYWORD)
  ) i_dfa (
    .clk       (clk),
    .rst_n     (rst_n),
    .char_in   (char_r),
    .char_vld  (char_vld_r),
    .state_in  (state_r),
    .state_vld (state_vld_r),
    .state_out (dfa_state),
    .accept    (dfa_accept)
  );

  assign out = '{fired: hit, count: count};

  // Scanner keeps the load pulse and characters apart
  a_no_char_on_load: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctl.char_vld && ctl.load_state));

endmodule

// ==== rule_slot/rule_dfa.sv ====
`include "kwm_consts.svh"

module rule_dfa #(
  parameter logic [8*`KWM_KEY_LEN-1:0] KEYWORD = `KWM_KEY0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [7:0]                 char_in,
  input  logic                       char_vld,
  input  logic [`KWM_STATE_BITS-1:0] state_in,
  input  logic                       state_vld,
  output logic [`KWM_STATE_BITS-1:0] state_out,
  output logic                       accept
);

  localparam int SB  = `KWM_STATE_BITS;
  localparam int LEN = `KWM_KEY_LEN;
  localparam logic [7:0] FIRST_CH = KEYWORD[8*LEN-1 -: 8];

  logic [SB-1:0] base;
  logic [SB-1:0] nxt;
  logic          nxt_acc;
  logic [7:0]    want_ch;

  // Keyword byte at a match position
  function automatic logic [7:0] key_byte(input logic [SB-1:0] pos);
    logic [7:0] b;
    b = 8'h00;
    for (int i = 0; i < LEN; i++)
    begin
      if (pos == SB'(i))
        b = KEYWORD[8*(LEN-1-i) +: 8];
    end
    return b;
  endfunction

  always_comb
  begin
    // Loaded state replaces the running one
    base    = state_vld ? state_in : state_out;
    want_ch = key_byte(base);
    nxt     = base;
    nxt_acc = 1'b0;
    if (char_vld)
    begin
      if (char_in == want_ch && base < SB'(LEN))
      begin
        // Full keyword seen, report and restart
        if (base == SB'(LEN - 1))
        begin
          nxt     = '0;
          nxt_acc = 1'b1;
        end
        else
          nxt = base + 1'b1;
      end
      // Mismatch may still open a new match
      else if (char_in == FIRST_CH)
        nxt = SB'(1);
      else
        nxt = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out <= '0;
      accept    <= 1'b0;
    end
    else
    begin
      state_out <= nxt;
      accept    <= nxt_acc;
    end
  end

endmodule

// ==== common/kwm_pkg.sv ====
`include "kwm_consts.svh"

package kwm_pkg;

  // Header view of an input word
  typedef struct packed {
    logic [14-`KWM_STREAM_BITS-`KWM_NUM_RULES:0] pad;
    logic [`KWM_NUM_RULES-1:0]                   rule_en;
    logic                                        new_stream;
    logic [`KWM_STREAM_BITS-1:0]                 stream_id;
  } beat_hdr_t;

  // Payload view, one character in the low byte
  typedef struct packed {
    logic [7:0] pad;
    logic [7:0] char;
  } beat_pay_t;

  // Same 16-bit word, decoded by the first flag of the beat
  typedef union packed {
    beat_hdr_t hdr;
    beat_pay_t pay;
  } beat_word_u;

  // One input beat per cycle
  typedef struct packed {
    logic       vld;
    logic       first;
    logic       last;
    beat_word_u word;
  } pkt_beat_t;

  // Scanner strobes, shared by all slots
  typedef struct packed {
    logic                        load_state;
    logic                        new_stream;
    logic [`KWM_STREAM_BITS-1:0] stream_id;
    logic                        char_vld;
    logic [7:0]                  char;
    logic                        eop;
    logic [`KWM_NUM_RULES-1:0]   rule_en;
  } slot_ctl_t;

  typedef struct packed {
    logic        fired;
    logic [15:0] count;
  } slot_out_t;

  typedef struct packed {
    logic                        vld;
    logic [`KWM_STREAM_BITS-1:0] stream_id;
    logic [`KWM_NUM_RULES-1:0]   hit_mask;
  } result_t;

endpackage

// ==== common/kwm_consts.svh ====
`ifndef KWM_CONSTS_SVH
`define KWM_CONSTS_SVH

// Number of rule slots
`define KWM_NUM_RULES 4
// Stream id width, 64 streams
`define KWM_STREAM_BITS 6
// Automaton state width
`define KWM_STATE_BITS 11
// Characters per keyword
`define KWM_KEY_LEN 4

// Literal keywords, first character in the top byte
`define KWM_KEY0 "USER"
`define KWM_KEY1 "PASS"
`define KWM_KEY2 "root"
`define KWM_KEY3 "exec"

// Cycles from last character strobe to end-of-packet strobe
`define KWM_EOP_DELAY 3
// Idle input cycles required between packets
`define KWM_MIN_GAP 5

`endif
